//--- noc_credit_in.sv
module noc_credit_in (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t in_flit
    ,input  logic                  in_val
    ,output logic                  in_yummy

    ,output noc_rx_pkg::noc_flit_t out_flit
    ,output logic                  out_val
    ,input  logic                  out_rdy
);

    noc_rx_pkg::noc_flit_t                 mem [noc_rx_pkg::NOC_CREDITS];
    logic [noc_rx_pkg::FIFO_IDX_W-1:0]     wr_ptr;
    logic [noc_rx_pkg::FIFO_IDX_W-1:0]     rd_ptr;
    logic [noc_rx_pkg::CREDIT_CNT_W-1:0]   count;
    logic                                  pop;

    assign out_val  = count != '0;
    assign out_flit = mem[rd_ptr];
    assign pop      = out_val & out_rdy;
    // one credit back per dequeued flit
    assign in_yummy = pop;

    // one entry per credit held by the sender
    always_ff @(posedge clk) begin
        if (in_val) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_val) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_val, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- noc_fbits_splitter.sv
module noc_fbits_splitter (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t in_flit
    ,input  logic                  in_val
    ,output logic                  in_rdy

    ,output noc_rx_pkg::noc_flit_t pay_flit
    ,output logic                  pay_val
    ,input  logic                  pay_rdy

    ,output noc_rx_pkg::noc_flit_t ptr_flit
    ,output logic                  ptr_val
    ,input  logic                  ptr_rdy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FWD,
        ST_DROP
    } state_t;

    state_t                 state;
    noc_rx_pkg::msg_len_t   remaining;
    logic                   tgt_pay;

    noc_rx_pkg::fbits_t     hdr_fbits;
    noc_rx_pkg::msg_len_t   hdr_len;
    logic                   hdr_pay;
    logic                   hdr_ptr;
    logic                   sel_pay;
    logic                   sel_ptr;
    logic                   xfer;

    assign hdr_fbits = in_flit[noc_rx_pkg::FBITS_HI:noc_rx_pkg::FBITS_LO];
    assign hdr_len   = in_flit[noc_rx_pkg::MSG_LEN_HI:noc_rx_pkg::MSG_LEN_LO];
    assign hdr_pay   = hdr_fbits == noc_rx_pkg::PAYLOAD_FBITS;
    assign hdr_ptr   = hdr_fbits == noc_rx_pkg::PTR_IF_FBITS;

    // target of the flit at the head of the input
    always_comb begin
        sel_pay = 1'b0;
        sel_ptr = 1'b0;
        case (state)
            ST_IDLE: begin
                sel_pay = hdr_pay;
                sel_ptr = hdr_ptr;
            end
            ST_FWD: begin
                sel_pay = tgt_pay;
                sel_ptr = ~tgt_pay;
            end
            default: begin
                sel_pay = 1'b0;
                sel_ptr = 1'b0;
            end
        endcase
    end

    assign pay_flit = in_flit;
    assign ptr_flit = in_flit;
    assign pay_val  = in_val & sel_pay;
    assign ptr_val  = in_val & sel_ptr;
    // unknown fbits are swallowed
    assign in_rdy   = sel_pay ? pay_rdy : (sel_ptr ? ptr_rdy : 1'b1);
    assign xfer     = in_val & in_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            remaining <= '0;
            tgt_pay   <= 1'b0;
        end else if (xfer) begin
            if (state == ST_IDLE) begin
                remaining <= hdr_len;
                tgt_pay   <= hdr_pay;
                if (hdr_len != '0) begin
                    state <= (hdr_pay | hdr_ptr) ? ST_FWD : ST_DROP;
                end
            end else begin
                remaining <= remaining - 1'b1;
                if (remaining == noc_rx_pkg::msg_len_t'(1)) begin
                    state <= ST_IDLE;
                end
            end
        end
    end

endmodule

//--- noc_reply_merger.sv
module noc_reply_merger (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t r0_flit
    ,input  logic                  r0_val
    ,output logic                  r0_rdy

    ,input  noc_rx_pkg::noc_flit_t r1_flit
    ,input  logic                  r1_val
    ,output logic                  r1_rdy

    ,output noc_rx_pkg::noc_flit_t out_flit
    ,output logic                  out_val
    ,input  logic                  out_yummy
);

    logic [noc_rx_pkg::CREDIT_CNT_W-1:0] credits;
    logic                                credit_ok;
    logic                                grant;

    assign credit_ok = credits != '0;
    // every reply is one flit, so no message lock
    assign r0_rdy    = credit_ok;
    assign r1_rdy    = credit_ok & ~r0_val;
    assign grant     = credit_ok & (r0_val | r1_val);

    always_ff @(posedge clk) begin
        if (grant) begin
            out_flit <= r0_val ? r0_flit : r1_flit;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_val <= 1'b0;
            credits <= noc_rx_pkg::CREDIT_CNT_W'(noc_rx_pkg::NOC_CREDITS);
        end else begin
            out_val <= grant;
            case ({out_yummy, grant})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- noc_rx_pkg.sv
package noc_rx_pkg;

    localparam int NOC_DATA_W   = 64;
    localparam int XY_W         = 4;
    localparam int FBITS_W      = 4;
    localparam int MSG_LEN_W    = 8;
    localparam int FLOW_ID_W    = 4;
    localparam int NUM_FLOWS    = 16;
    localparam int PTR_W        = 16;
    localparam int NOC_CREDITS  = 4;
    localparam int CREDIT_CNT_W = $clog2(NOC_CREDITS + 1);
    localparam int FIFO_IDX_W   = $clog2(NOC_CREDITS);
    localparam int CSUM_WORDS   = NOC_DATA_W / PTR_W;

    // header flit layout
    localparam int DST_X_HI   = 63;
    localparam int DST_X_LO   = 60;
    localparam int DST_Y_HI   = 59;
    localparam int DST_Y_LO   = 56;
    localparam int FBITS_HI   = 55;
    localparam int FBITS_LO   = 52;
    localparam int MSG_LEN_HI = 51;
    localparam int MSG_LEN_LO = 44;
    localparam int SRC_X_HI   = 43;
    localparam int SRC_X_LO   = 40;
    localparam int SRC_Y_HI   = 39;
    localparam int SRC_Y_LO   = 36;
    localparam int OPCODE_HI  = 35;
    localparam int OPCODE_LO  = 32;
    localparam int FLOW_ID_HI = 31;
    localparam int FLOW_ID_LO = 28;
    localparam int VALUE_HI   = 15;
    localparam int VALUE_LO   = 0;

    typedef logic [NOC_DATA_W-1:0] noc_flit_t;
    typedef logic [XY_W-1:0]       xy_t;
    typedef logic [FBITS_W-1:0]    fbits_t;
    typedef logic [MSG_LEN_W-1:0]  msg_len_t;
    typedef logic [FLOW_ID_W-1:0]  flow_id_t;
    typedef logic [PTR_W-1:0]      ptr_t;

    typedef enum logic [3:0] {
        PTR_WR    = 4'd1,
        PTR_RD    = 4'd2,
        PTR_RESP  = 4'd3,
        CSUM_RESP = 4'd4
    } opcode_t;

    localparam fbits_t PAYLOAD_FBITS = 4'h1;
    localparam fbits_t PTR_IF_FBITS  = 4'h2;
    localparam fbits_t REPLY_FBITS   = 4'h8;

    // single header flit reply of length zero
    function automatic noc_flit_t make_reply(
        input xy_t      dst_x,
        input xy_t      dst_y,
        input xy_t      src_x,
        input xy_t      src_y,
        input opcode_t  op,
        input flow_id_t flow,
        input ptr_t     value
    );
        noc_flit_t flit;
        flit = '0;
        flit[DST_X_HI:DST_X_LO]     = dst_x;
        flit[DST_Y_HI:DST_Y_LO]     = dst_y;
        flit[FBITS_HI:FBITS_LO]     = REPLY_FBITS;
        flit[SRC_X_HI:SRC_X_LO]     = src_x;
        flit[SRC_Y_HI:SRC_Y_LO]     = src_y;
        flit[OPCODE_HI:OPCODE_LO]   = op;
        flit[FLOW_ID_HI:FLOW_ID_LO] = flow;
        flit[VALUE_HI:VALUE_LO]     = value;
        return flit;
    endfunction

    // 16-bit ones' complement add with end-around carry
    function automatic ptr_t csum_add(input ptr_t a, input ptr_t b);
        logic [PTR_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        return ptr_t'(s[PTR_W-1:0] + {{(PTR_W-1){1'b0}}, s[PTR_W]});
    endfunction

endpackage

//--- noc_rx_tile.f
noc_rx_pkg.sv
noc_credit_in.sv
noc_fbits_splitter.sv
rx_payload_csum.sv
rx_ptr_table.sv
noc_reply_merger.sv
noc_rx_tile.sv
tb_noc_rx_tile.sv

//--- noc_rx_tile.sv
module noc_rx_tile #(
     parameter int src_x = 0
    ,parameter int src_y = 0
)(
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t in_flit
    ,input  logic                  in_val
    ,output logic                  in_yummy

    ,output noc_rx_pkg::noc_flit_t out_flit
    ,output logic                  out_val
    ,input  logic                  out_yummy
);

    noc_rx_pkg::noc_flit_t  cin_flit;
    logic                   cin_val;
    logic                   cin_rdy;

    noc_rx_pkg::noc_flit_t  pay_flit;
    logic                   pay_val;
    logic                   pay_rdy;

    noc_rx_pkg::noc_flit_t  ptr_flit;
    logic                   ptr_val;
    logic                   ptr_rdy;

    noc_rx_pkg::noc_flit_t  r0_flit;
    logic                   r0_val;
    logic                   r0_rdy;

    noc_rx_pkg::noc_flit_t  r1_flit;
    logic                   r1_val;
    logic                   r1_rdy;

    noc_credit_in u_credit_in (
         .clk       (clk        )
        ,.arst_n    (arst_n     )
        ,.in_flit   (in_flit    )
        ,.in_val    (in_val     )
        ,.in_yummy  (in_yummy   )
        ,.out_flit  (cin_flit   )
        ,.out_val   (cin_val    )
        ,.out_rdy   (cin_rdy    )
    );

    noc_fbits_splitter u_splitter (
         .clk       (clk        )
        ,.arst_n    (arst_n     )
        ,.in_flit   (cin_flit   )
        ,.in_val    (cin_val    )
        ,.in_rdy    (cin_rdy    )
        ,.pay_flit  (pay_flit   )
        ,.pay_val   (pay_val    )
        ,.pay_rdy   (pay_rdy    )
        ,.ptr_flit  (ptr_flit   )
        ,.ptr_val   (ptr_val    )
        ,.ptr_rdy   (ptr_rdy    )
    );

    rx_payload_csum #(
         .src_x (src_x)
        ,.src_y (src_y)
    ) u_payload_csum (
         .clk           (clk        )
        ,.arst_n        (arst_n     )
        ,.in_flit       (pay_flit   )
        ,.in_val        (pay_val    )
        ,.in_rdy        (pay_rdy    )
        ,.reply_flit    (r0_flit    )
        ,.reply_val     (r0_val     )
        ,.reply_rdy     (r0_rdy     )
    );

    rx_ptr_table #(
         .src_x (src_x)
        ,.src_y (src_y)
    ) u_ptr_table (
         .clk           (clk        )
        ,.arst_n        (arst_n     )
        ,.in_flit       (ptr_flit   )
        ,.in_val        (ptr_val    )
        ,.in_rdy        (ptr_rdy    )
        ,.reply_flit    (r1_flit    )
        ,.reply_val     (r1_val     )
        ,.reply_rdy     (r1_rdy     )
    );

    // payload replies win over pointer replies
    noc_reply_merger u_reply_merger (
         .clk       (clk        )
        ,.arst_n    (arst_n     )
        ,.r0_flit   (r0_flit    )
        ,.r0_val    (r0_val     )
        ,.r0_rdy    (r0_rdy     )
        ,.r1_flit   (r1_flit    )
        ,.r1_val    (r1_val     )
        ,.r1_rdy    (r1_rdy     )
        ,.out_flit  (out_flit   )
        ,.out_val   (out_val    )
        ,.out_yummy (out_yummy  )
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_noc_rx_tile -f noc_rx_tile.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- rx_payload_csum.sv
module rx_payload_csum #(
     parameter int src_x = 0
    ,parameter int src_y = 0
)(
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t in_flit
    ,input  logic                  in_val
    ,output logic                  in_rdy

    ,output noc_rx_pkg::noc_flit_t reply_flit
    ,output logic                  reply_val
    ,input  logic                  reply_rdy
);

    typedef enum logic {
        ST_HDR,
        ST_BODY
    } state_t;

    state_t                 state;
    noc_rx_pkg::msg_len_t   remaining;
    noc_rx_pkg::ptr_t       sum;
    noc_rx_pkg::xy_t        req_x;
    noc_rx_pkg::xy_t        req_y;
    noc_rx_pkg::flow_id_t   req_flow;

    noc_rx_pkg::noc_flit_t  q_mem [2];
    logic                   q_wr;
    logic                   q_rd;
    logic [1:0]             q_cnt;

    noc_rx_pkg::ptr_t       sum_next;
    noc_rx_pkg::xy_t        rep_x;
    noc_rx_pkg::xy_t        rep_y;
    noc_rx_pkg::flow_id_t   rep_flow;
    noc_rx_pkg::ptr_t       rep_sum;
    logic                   is_hdr;
    logic                   last_flit;
    logic                   xfer;
    logic                   q_push;
    logic                   q_pop;

    // fold the four words of the current flit into the running sum
    always_comb begin
        sum_next = sum;
        for (int i = 0; i < noc_rx_pkg::CSUM_WORDS; i++) begin
            sum_next = noc_rx_pkg::csum_add(sum_next,
                in_flit[i*noc_rx_pkg::PTR_W +: noc_rx_pkg::PTR_W]);
        end
    end

    assign is_hdr    = state == ST_HDR;
    assign last_flit = is_hdr
        ? (in_flit[noc_rx_pkg::MSG_LEN_HI:noc_rx_pkg::MSG_LEN_LO] == '0)
        : (remaining == noc_rx_pkg::msg_len_t'(1));
    // stall only a flit that would push into a full queue
    assign in_rdy    = ~(last_flit & (q_cnt == 2'd2));
    assign xfer      = in_val & in_rdy;
    assign q_push    = xfer & last_flit;
    assign q_pop     = reply_val & reply_rdy;

    // zero-length message replies straight from its header
    assign rep_x    = is_hdr ? in_flit[noc_rx_pkg::SRC_X_HI:noc_rx_pkg::SRC_X_LO] : req_x;
    assign rep_y    = is_hdr ? in_flit[noc_rx_pkg::SRC_Y_HI:noc_rx_pkg::SRC_Y_LO] : req_y;
    assign rep_flow = is_hdr ? in_flit[noc_rx_pkg::FLOW_ID_HI:noc_rx_pkg::FLOW_ID_LO]
                             : req_flow;
    assign rep_sum  = is_hdr ? '0 : sum_next;

    assign reply_val  = q_cnt != 2'd0;
    assign reply_flit = q_mem[q_rd];

    always_ff @(posedge clk) begin
        if (xfer) begin
            if (is_hdr) begin
                sum      <= '0;
                req_x    <= rep_x;
                req_y    <= rep_y;
                req_flow <= rep_flow;
            end else begin
                sum <= sum_next;
            end
        end
        if (q_push) begin
            q_mem[q_wr] <= noc_rx_pkg::make_reply(rep_x, rep_y,
                noc_rx_pkg::xy_t'(src_x), noc_rx_pkg::xy_t'(src_y),
                noc_rx_pkg::CSUM_RESP, rep_flow, rep_sum);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_HDR;
            remaining <= '0;
            q_wr      <= 1'b0;
            q_rd      <= 1'b0;
            q_cnt     <= 2'd0;
        end else begin
            if (xfer) begin
                state <= last_flit ? ST_HDR : ST_BODY;
                if (is_hdr) begin
                    remaining <= in_flit[noc_rx_pkg::MSG_LEN_HI:noc_rx_pkg::MSG_LEN_LO];
                end else begin
                    remaining <= remaining - 1'b1;
                end
            end
            if (q_push) begin
                q_wr <= ~q_wr;
            end
            if (q_pop) begin
                q_rd <= ~q_rd;
            end
            case ({q_push, q_pop})
                2'b10:   q_cnt <= q_cnt + 2'd1;
                2'b01:   q_cnt <= q_cnt - 2'd1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

endmodule

//--- rx_ptr_table.sv
module rx_ptr_table #(
     parameter int src_x = 0
    ,parameter int src_y = 0
)(
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  noc_rx_pkg::noc_flit_t in_flit
    ,input  logic                  in_val
    ,output logic                  in_rdy

    ,output noc_rx_pkg::noc_flit_t reply_flit
    ,output logic                  reply_val
    ,input  logic                  reply_rdy
);

    noc_rx_pkg::ptr_t       ptr_tbl [noc_rx_pkg::NUM_FLOWS];
    noc_rx_pkg::msg_len_t   remaining;

    noc_rx_pkg::opcode_t    req_op;
    noc_rx_pkg::flow_id_t   req_flow;
    logic                   is_hdr;
    logic                   xfer;
    logic                   hdr_xfer;

    assign req_op   = noc_rx_pkg::opcode_t'(in_flit[noc_rx_pkg::OPCODE_HI:noc_rx_pkg::OPCODE_LO]);
    assign req_flow = in_flit[noc_rx_pkg::FLOW_ID_HI:noc_rx_pkg::FLOW_ID_LO];
    // body count drained means the next flit is a header
    assign is_hdr   = remaining == '0;
    assign in_rdy   = ~reply_val;
    assign xfer     = in_val & in_rdy;
    assign hdr_xfer = xfer & is_hdr;

    always_ff @(posedge clk) begin
        if (hdr_xfer && req_op == noc_rx_pkg::PTR_RD) begin
            reply_flit <= noc_rx_pkg::make_reply(
                in_flit[noc_rx_pkg::SRC_X_HI:noc_rx_pkg::SRC_X_LO],
                in_flit[noc_rx_pkg::SRC_Y_HI:noc_rx_pkg::SRC_Y_LO],
                noc_rx_pkg::xy_t'(src_x), noc_rx_pkg::xy_t'(src_y),
                noc_rx_pkg::PTR_RESP, req_flow, ptr_tbl[req_flow]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
            reply_val <= 1'b0;
            for (int i = 0; i < noc_rx_pkg::NUM_FLOWS; i++) begin
                ptr_tbl[i] <= '0;
            end
        end else begin
            if (xfer) begin
                remaining <= is_hdr
                    ? in_flit[noc_rx_pkg::MSG_LEN_HI:noc_rx_pkg::MSG_LEN_LO]
                    : remaining - 1'b1;
            end
            if (hdr_xfer && req_op == noc_rx_pkg::PTR_WR) begin
                ptr_tbl[req_flow] <= in_flit[noc_rx_pkg::VALUE_HI:noc_rx_pkg::VALUE_LO];
            end
            if (hdr_xfer && req_op == noc_rx_pkg::PTR_RD) begin
                reply_val <= 1'b1;
            end else if (reply_rdy) begin
                reply_val <= 1'b0;
            end
        end
    end

endmodule

//--- tb_noc_rx_tile.sv
module tb_noc_rx_tile;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TILE_X = 3;
    localparam int TILE_Y = 5;
    localparam int REQ_X = 1;
    localparam int REQ_Y = 2;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic arst_n;
    noc_rx_pkg::noc_flit_t in_flit;
    logic in_val;
    logic in_yummy;
    noc_rx_pkg::noc_flit_t out_flit;
    logic out_val;
    logic out_yummy;

    int seed = 32'h9b83;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int sent_cnt = 0;
    int yummy_cnt = 0;
    int rx_cnt = 0;
    int exp_total = 0;
    int owed = 0;
    logic yummy_en = 1'b1;

    noc_rx_pkg::noc_flit_t csum_q[$];
    noc_rx_pkg::noc_flit_t ptr_q[$];
    noc_rx_pkg::noc_flit_t body_q[$];
    // model of the head-pointer table
    logic [15:0] tbl [16];

    noc_rx_tile #(
         .src_x (TILE_X)
        ,.src_y (TILE_Y)
    ) u_noc_rx_tile (
         .clk       (clk      )
        ,.arst_n    (arst_n   )
        ,.in_flit   (in_flit  )
        ,.in_val    (in_val   )
        ,.in_yummy  (in_yummy )
        ,.out_flit  (out_flit )
        ,.out_val   (out_val  )
        ,.out_yummy (out_yummy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (in_yummy) begin
            yummy_cnt <= yummy_cnt + 1;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic noc_rx_pkg::noc_flit_t mk_header(input logic [3:0] fbits,
            input logic [7:0] len, input logic [3:0] op, input logic [3:0] flow,
            input logic [15:0] value);
        noc_rx_pkg::noc_flit_t h;
        h = '0;
        h[63:60] = 4'(TILE_X);
        h[59:56] = 4'(TILE_Y);
        h[55:52] = fbits;
        h[51:44] = len;
        h[43:40] = 4'(REQ_X);
        h[39:36] = 4'(REQ_Y);
        h[35:32] = op;
        h[31:28] = flow;
        h[15:0] = value;
        return h;
    endfunction

    // expected reply for a request header whose body sits in body_q
    function automatic noc_rx_pkg::noc_flit_t expected_reply(input noc_rx_pkg::noc_flit_t hdr);
        noc_rx_pkg::noc_flit_t r;
        logic [31:0] acc;
        logic [15:0] value;
        logic [3:0] op;
        acc = '0;
        if (hdr[55:52] == 4'h1) begin
            foreach (body_q[i]) begin
                for (int w = 0; w < 4; w++) begin
                    acc = acc + {16'h0, body_q[i][w*16 +: 16]};
                end
            end
            // fold carries back in
            while (acc[31:16] != 16'h0) begin
                acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
            end
            value = acc[15:0];
            op = 4'd4;
        end else begin
            value = tbl[hdr[31:28]];
            op = 4'd3;
        end
        r = '0;
        r[63:60] = hdr[43:40];
        r[59:56] = hdr[39:36];
        r[55:52] = 4'h8;
        r[43:40] = 4'(TILE_X);
        r[39:36] = 4'(TILE_Y);
        r[35:32] = op;
        r[31:28] = hdr[31:28];
        r[15:0] = value;
        return r;
    endfunction

    task automatic fill_body(input int n);
        body_q.delete();
        repeat (n) begin
            body_q.push_back({$random(seed), $random(seed)});
        end
    endtask

    task automatic send_flit(input noc_rx_pkg::noc_flit_t f);
        int waited;
        waited = 0;
        @(posedge clk);
        while (sent_cnt - yummy_cnt >= noc_rx_pkg::NOC_CREDITS && waited < TIMEOUT_CYCLES) begin
            in_val <= 1'b0;
            waited++;
            @(posedge clk);
        end
        if (waited >= TIMEOUT_CYCLES) begin
            $display("timeout waiting for an input credit");
            errors++;
        end
        in_flit <= f;
        in_val <= 1'b1;
        sent_cnt++;
    endtask

    task automatic send_request(input noc_rx_pkg::noc_flit_t hdr);
        if (hdr[55:52] == 4'h1) begin
            csum_q.push_back(expected_reply(hdr));
            exp_total++;
        end else if (hdr[55:52] == 4'h2 && hdr[35:32] == 4'd2) begin
            ptr_q.push_back(expected_reply(hdr));
            exp_total++;
        end else if (hdr[55:52] == 4'h2 && hdr[35:32] == 4'd1) begin
            tbl[hdr[31:28]] = hdr[15:0];
        end
        send_flit(hdr);
        foreach (body_q[i]) begin
            send_flit(body_q[i]);
        end
        @(posedge clk);
        in_val <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while ((csum_q.size() != 0 || ptr_q.size() != 0) && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= TIMEOUT_CYCLES) begin
            $display("timeout: replies for %s never arrived", what);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %s: %s", name, errors == errs_before ? "ok" : "FAILED");
    endtask

    // compare replies and hand back one yummy per flit
    always @(posedge clk) begin : compare_proc
        logic [3:0] op;
        if (out_val) begin
            op = out_flit[35:32];
            rx_cnt++;
            owed++;
            if (op == 4'd4 && csum_q.size() > 0) begin
                check_val("out_flit", out_flit, csum_q.pop_front());
            end else if (op == 4'd3 && ptr_q.size() > 0) begin
                check_val("out_flit", out_flit, ptr_q.pop_front());
            end else begin
                $display("reply %h arrived with no request waiting for it", out_flit);
                errors++;
            end
        end
        if (yummy_en && owed > 0) begin
            out_yummy <= 1'b1;
            owed--;
        end else begin
            out_yummy <= 1'b0;
        end
    end

    initial begin : main_proc
        int e0;
        int rx0;
        int waited;
        clk = 1'b0;
        arst_n = 1'b0;
        in_flit = '0;
        in_val = 1'b0;
        out_yummy = 1'b0;
        for (int i = 0; i < 16; i++) begin
            tbl[i] = 16'h0;
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        e0 = errors;
        body_q.delete();
        send_request(mk_header(4'h2, 8'd0, 4'd2, 4'd4, 16'h0));
        send_request(mk_header(4'h2, 8'd0, 4'd1, 4'd1, 16'h1234));
        send_request(mk_header(4'h2, 8'd0, 4'd1, 4'd7, 16'hbeef));
        send_request(mk_header(4'h2, 8'd0, 4'd1, 4'd15, 16'h00a5));
        send_request(mk_header(4'h2, 8'd0, 4'd2, 4'd1, 16'h0));
        send_request(mk_header(4'h2, 8'd0, 4'd2, 4'd7, 16'h0));
        send_request(mk_header(4'h2, 8'd0, 4'd2, 4'd15, 16'h0));
        wait_drain("pointer table");
        report_test("pointer table", e0);

        e0 = errors;
        fill_body(0);
        send_request(mk_header(4'h1, 8'd0, 4'd0, 4'd2, 16'h0));
        fill_body(1);
        send_request(mk_header(4'h1, 8'd1, 4'd0, 4'd3, 16'h0));
        fill_body(7);
        send_request(mk_header(4'h1, 8'd7, 4'd0, 4'd4, 16'h0));
        wait_drain("checksum");
        report_test("checksum", e0);

        e0 = errors;
        fill_body(3);
        send_request(mk_header(4'h5, 8'd3, 4'd0, 4'd9, 16'h0));
        body_q.delete();
        send_request(mk_header(4'h2, 8'd0, 4'd2, 4'd7, 16'h0));
        wait_drain("unknown fbits");
        check_val("out_val count", 64'(rx_cnt), 64'(exp_total));
        report_test("unknown fbits", e0);

        e0 = errors;
        yummy_en <= 1'b0;
        rx0 = rx_cnt;
        fill_body(0);
        for (int i = 0; i < 3; i++) begin
            send_request(mk_header(4'h1, 8'd0, 4'd0, 4'(i + 10), 16'h0));
            send_request(mk_header(4'h2, 8'd0, 4'd2, 4'(i + 1), 16'h0));
        end
        wait_cycles(40);
        check_val("out_val count", 64'(rx_cnt - rx0), 64'(noc_rx_pkg::NOC_CREDITS));
        @(posedge clk);
        yummy_en <= 1'b1;
        wait_drain("output back-pressure");
        check_val("out_val count", 64'(rx_cnt), 64'(exp_total));
        report_test("output back-pressure", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            fill_body(i % 3 + 1);
            send_request(mk_header(4'h1, 8'(i % 3 + 1), 4'd0, 4'(i), 16'h0));
            body_q.delete();
            send_request(mk_header(4'h2, 8'd0, 4'd1, 4'(i + 8), 16'($random(seed))));
            send_request(mk_header(4'h2, 8'd0, 4'd2, 4'(i + 8), 16'h0));
            send_request(mk_header(4'h1, 8'd0, 4'd0, 4'(i + 8), 16'h0));
        end
        wait_drain("mixed traffic");
        check_val("out_val count", 64'(rx_cnt), 64'(exp_total));
        report_test("mixed traffic", e0);

        e0 = errors;
        waited = 0;
        @(negedge clk);
        while (yummy_cnt != sent_cnt && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= TIMEOUT_CYCLES) begin
            $display("timeout: input credits were not all returned");
            errors++;
        end
        check_val("in_yummy count", 64'(yummy_cnt), 64'(sent_cnt));
        report_test("credit return", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
